/* verilog/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

    // ************************************************************
    // instruction kinds, in power-up order first
    // ************************************************************
    typedef enum logic [2:0] {
        INST_PRECHARGE  = 3'd0,
        INST_FUNC_SET   = 3'd1,
        INST_DISP_ON    = 3'd2,
        INST_CLEAR      = 3'd3,
        INST_ENTRY_MODE = 3'd4,
        INST_SET_ADDR   = 3'd5,
        INST_WRITE_DATA = 3'd6
    } lcd_inst_e;

    // bus word {rs, rw, db[7:0]} seen as a plain byte or as a DDRAM address command
    typedef union packed {
        struct packed {
            logic       rs;
            logic       rw;
            logic [7:0] data;
        } cmd;
        struct packed {
            logic       rs;
            logic       rw;
            logic       addr_cmd;   // db7 set for set-DDRAM-address
            logic [6:0] addr;
        } set_addr;
    } lcd_word_u;

    // ************************************************************
    // base words and execution times, indexed by lcd_inst_e
    // ************************************************************
    localparam logic [9:0] INST_WORD [0:6] = '{
        10'b00_0011_0000,   // precharge, 8-bit interface
        10'b00_0011_1000,   // function set, 2 lines, 5x8 font
        10'b00_0000_1100,   // display on, no cursor
        10'b00_0000_0001,   // clear display
        10'b00_0000_0110,   // entry mode, increment
        10'b00_1000_0000,   // set address, address filled in
        10'b10_0000_0000    // write data, byte filled in
    };

    localparam logic [14:0] INST_TIME_US [0:6] = '{
        15'd15000, 15'd39, 15'd39, 15'd1530, 15'd39, 15'd39, 15'd43
    };

    localparam logic [6:0] LINE1_ADDR = 7'h00;
    localparam logic [6:0] LINE2_ADDR = 7'h40;
    localparam int         LCD_COLS   = 16;   // characters per line

endpackage

`default_nettype wire

/* verilog/lcd_exec_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module lcd_exec_timer #(
    parameter int TICKS_PER_US = 1
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_start,
    input  logic [14:0] i_limit,    // microseconds
    output logic        o_expired,
    output logic        o_busy
);

    localparam int PRE_W = (TICKS_PER_US > 1) ? $clog2(TICKS_PER_US) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICKS_PER_US - 1);

    logic [PRE_W-1:0] pre_r;      // ticks within the current microsecond
    logic [14:0]      us_r;       // whole microseconds elapsed
    logic [14:0]      limit_r;
    logic             run_r;
    logic             expired_r;
    logic             last_tick;

    assign last_tick = (pre_r == PRE_LAST) && (us_r == limit_r - 15'd1);
    assign o_expired = expired_r;
    assign o_busy    = run_r;

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            limit_r <= i_limit;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            run_r     <= 1'b0;
            expired_r <= 1'b0;
            pre_r     <= '0;
            us_r      <= 15'd0;
        end else begin
            expired_r <= 1'b0;
            if (i_start) begin
                run_r <= 1'b1;
                pre_r <= '0;
                us_r  <= 15'd0;
            end else if (run_r) begin
                if (last_tick) begin
                    run_r     <= 1'b0;
                    expired_r <= 1'b1;  // single pulse
                end else if (pre_r == PRE_LAST) begin
                    pre_r <= '0;
                    us_r  <= us_r + 15'd1;
                end else begin
                    pre_r <= pre_r + PRE_W'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/lcd_instructions.sv */
`timescale 1ns/1ns
`default_nettype none

module lcd_instructions import lcd_pkg::*; #(
    parameter int TICKS_PER_US = 1
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  lcd_inst_e  i_type,
    input  logic [6:0] i_address,
    input  logic [7:0] i_char,
    output logic       o_lcd_en,
    output logic       o_lcd_rs,
    output logic       o_lcd_rw,
    output logic [7:0] o_lcd_data,
    output logic       o_finish
);

    localparam logic S_IDLE = 1'b0;
    localparam logic S_EXE  = 1'b1;

    logic        state_r, state_w;
    lcd_word_u   word_r, word_w;
    logic        en_r, en_w;
    logic        finish_r, finish_w;
    logic        tmr_start;
    logic [14:0] tmr_limit;
    logic        tmr_expired;

    assign o_lcd_en   = en_r;
    assign o_lcd_rs   = word_r.cmd.rs;
    assign o_lcd_rw   = word_r.cmd.rw;
    assign o_lcd_data = word_r.cmd.data;
    assign o_finish   = finish_r;

    assign tmr_limit  = INST_TIME_US[i_type];   // scaled to ticks inside the timer

    always_comb begin
        state_w   = state_r;
        word_w    = word_r;
        en_w      = 1'b0;
        finish_w  = 1'b0;
        tmr_start = 1'b0;
        case (state_r)
            S_IDLE: begin
                if (i_start) begin
                    state_w   = S_EXE;
                    en_w      = 1'b1;
                    tmr_start = 1'b1;
                    word_w    = INST_WORD[i_type];
                    if (i_type == INST_SET_ADDR) begin
                        word_w.set_addr.addr = i_address;
                    end else if (i_type == INST_WRITE_DATA) begin
                        word_w.cmd.data = i_char;
                    end
                end
            end
            S_EXE: begin
                if (tmr_expired) begin
                    state_w  = S_IDLE;
                    finish_w = 1'b1;
                end
            end
            default: state_w = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r  <= S_IDLE;
            word_r   <= '0;     // bus idles low
            en_r     <= 1'b0;
            finish_r <= 1'b0;
        end else begin
            state_r  <= state_w;
            word_r   <= word_w;
            en_r     <= en_w;
            finish_r <= finish_w;
        end
    end

    lcd_exec_timer #(
        .TICKS_PER_US(TICKS_PER_US)
    ) u_timer (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (tmr_start),
        .i_limit  (tmr_limit),
        .o_expired(tmr_expired),
        .o_busy   ()
    );

endmodule

`default_nettype wire

/* verilog/lcd_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module lcd_sequencer import lcd_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_refresh,
    input  logic       i_finish,
    input  logic [7:0] i_rd_char,
    output logic       o_start,
    output lcd_inst_e  o_type,
    output logic [6:0] o_addr,
    output logic [7:0] o_char,
    output logic [4:0] o_rd_idx,
    output logic       o_ready,
    output logic       o_busy,
    output logic       o_done
);

    localparam logic [2:0] S_INIT   = 3'd0;
    localparam logic [2:0] S_READY  = 3'd1;
    localparam logic [2:0] S_SET_L1 = 3'd2;
    localparam logic [2:0] S_WR_L1  = 3'd3;
    localparam logic [2:0] S_SET_L2 = 3'd4;
    localparam logic [2:0] S_WR_L2  = 3'd5;

    localparam logic [3:0] LAST_COL  = 4'(LCD_COLS - 1);
    localparam logic [2:0] LAST_STEP = 3'(INST_ENTRY_MODE);

    logic [2:0] state_r, state_w;
    logic [2:0] step_r, step_w;     // init instruction index
    logic [3:0] col_r, col_w;
    logic       go_r, go_w;
    logic       done_r, done_w;
    logic       line2;

    assign line2    = (state_r == S_SET_L2) || (state_r == S_WR_L2);
    assign o_start  = go_r;
    assign o_addr   = line2 ? LINE2_ADDR : LINE1_ADDR;
    assign o_rd_idx = {line2, col_r};   // line * 16 + column
    assign o_char   = i_rd_char;
    assign o_ready  = (state_r == S_READY);
    assign o_busy   = !o_ready;
    assign o_done   = done_r;

    always_comb begin
        case (state_r)
            S_INIT:             o_type = lcd_inst_e'(step_r);
            S_SET_L1, S_SET_L2: o_type = INST_SET_ADDR;
            default:            o_type = INST_WRITE_DATA;
        endcase
    end

    // ************************************************************
    // next start is raised on the edge that sees finish
    // ************************************************************
    always_comb begin
        state_w = state_r;
        step_w  = step_r;
        col_w   = col_r;
        go_w    = 1'b0;
        done_w  = 1'b0;
        case (state_r)
            S_INIT: begin
                if (i_finish) begin
                    if (step_r == LAST_STEP) begin
                        state_w = S_READY;
                    end else begin
                        step_w = step_r + 3'd1;
                        go_w   = 1'b1;
                    end
                end
            end
            S_READY: begin
                if (i_refresh) begin
                    state_w = S_SET_L1;
                    go_w    = 1'b1;
                end
            end
            S_SET_L1, S_SET_L2: begin
                if (i_finish) begin
                    state_w = (state_r == S_SET_L1) ? S_WR_L1 : S_WR_L2;
                    col_w   = 4'd0;
                    go_w    = 1'b1;
                end
            end
            S_WR_L1: begin
                if (i_finish) begin
                    go_w = 1'b1;
                    if (col_r == LAST_COL) begin
                        state_w = S_SET_L2;
                    end else begin
                        col_w = col_r + 4'd1;
                    end
                end
            end
            S_WR_L2: begin
                if (i_finish) begin
                    if (col_r == LAST_COL) begin
                        state_w = S_READY;
                        done_w  = 1'b1;
                    end else begin
                        col_w = col_r + 4'd1;
                        go_w  = 1'b1;
                    end
                end
            end
            default: state_w = S_INIT;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r <= S_INIT;
            step_r  <= 3'd0;
            col_r   <= 4'd0;
            go_r    <= 1'b1;    // first init step issues right after reset
            done_r  <= 1'b0;
        end else begin
            state_r <= state_w;
            step_r  <= step_w;
            col_r   <= col_w;
            go_r    <= go_w;
            done_r  <= done_w;
        end
    end

endmodule

`default_nettype wire

/* verilog/lcd_char_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module lcd_char_buffer (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_wr_en,
    input  logic [4:0] i_wr_addr,
    input  logic [7:0] i_wr_char,
    input  logic [4:0] i_rd_idx,
    output logic [7:0] o_rd_char
);

    localparam logic [7:0] BLANK = 8'h20;   // ascii space

    logic [7:0] chars_r [0:31];

    // read is combinational so a late host write still reaches the panel
    assign o_rd_char = chars_r[i_rd_idx];

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                chars_r[i] <= BLANK;
            end
        end else if (i_wr_en) begin
            chars_r[i_wr_addr] <= i_wr_char;
        end
    end

endmodule

`default_nettype wire

/* verilog/lcd_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lcd_top import lcd_pkg::*; #(
    parameter int TICKS_PER_US = 1      // clock ticks per microsecond
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_wr_en,
    input  logic [4:0] i_wr_addr,
    input  logic [7:0] i_wr_char,
    input  logic       i_refresh,
    output logic       o_lcd_en,
    output logic       o_lcd_rs,
    output logic       o_lcd_rw,
    output logic [7:0] o_lcd_data,
    output logic       o_ready,
    output logic       o_busy,
    output logic       o_done
);

    logic       seq_start;
    lcd_inst_e  seq_type;
    logic [6:0] seq_addr;
    logic [7:0] seq_char;
    logic [4:0] rd_idx;
    logic [7:0] rd_char;
    logic       exe_finish;

    // ************************************************************
    // sequencer -> executor, buffer on the side
    // ************************************************************
    lcd_sequencer u_seq (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_refresh(i_refresh),
        .i_finish (exe_finish),
        .i_rd_char(rd_char),
        .o_start  (seq_start),
        .o_type   (seq_type),
        .o_addr   (seq_addr),
        .o_char   (seq_char),
        .o_rd_idx (rd_idx),
        .o_ready  (o_ready),
        .o_busy   (o_busy),
        .o_done   (o_done)
    );

    lcd_instructions #(
        .TICKS_PER_US(TICKS_PER_US)
    ) u_exe (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (seq_start),
        .i_type    (seq_type),
        .i_address (seq_addr),
        .i_char    (seq_char),
        .o_lcd_en  (o_lcd_en),
        .o_lcd_rs  (o_lcd_rs),
        .o_lcd_rw  (o_lcd_rw),
        .o_lcd_data(o_lcd_data),
        .o_finish  (exe_finish)
    );

    lcd_char_buffer u_buf (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_wr_en  (i_wr_en),
        .i_wr_addr(i_wr_addr),
        .i_wr_char(i_wr_char),
        .i_rd_idx (rd_idx),
        .o_rd_char(rd_char)
    );

endmodule

`default_nettype wire

/* test/tb_lcd_tasks.svh */
`ifndef TB_LCD_TASKS_SVH
`define TB_LCD_TASKS_SVH

// ************************************************************
// compare tasks
// ************************************************************
task automatic check_word(input string name, input lcd_word_u exp, input lcd_word_u act);
    n_checks++;
    if (act !== exp) begin
        n_errors++;
        $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_gap(input string name, input int exp, input int act);
    n_checks++;
    if (act != exp) begin
        n_errors++;
        $display("FAIL %s: expected %0d cycles, actual %0d cycles", name, exp, act);
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    n_checks++;
    if (act != exp) begin
        n_errors++;
        $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
        n_errors++;
        $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic start_test(input string name);
    cur_test    = name;
    test_errors = n_errors;
    n_tests++;
endtask

task automatic finish_test();
    $display("[%s] finished, %0d errors", cur_test, n_errors - test_errors);
endtask

task automatic check_idle_outputs(input string tag);
    check_word({tag, " bus"}, '0, bus_word);
    check_flag({tag, " en"}, 1'b0, o_lcd_en);
    check_flag({tag, " ready"}, 1'b0, o_ready);
    check_flag({tag, " done"}, 1'b0, o_done);
    check_flag({tag, " busy"}, 1'b1, o_busy);     // init still pending
endtask

// line 1 address, 16 chars, line 2 address, 16 chars
task automatic check_refresh();
    lcd_word_u exp;
    int        k;
    check_count({cur_test, " words"}, 34, word_q.size());
    check_count({cur_test, " done pulses"}, 1, done_cnt - done_base);
    check_flag({cur_test, " ready"}, 1'b1, o_ready);
    check_flag({cur_test, " busy"}, 1'b0, o_busy);
    if (word_q.size() == 34) begin
        for (int i = 0; i < 34; i++) begin
            exp = '0;
            if (i == 0 || i == 17) begin
                exp.set_addr.addr_cmd = 1'b1;
                exp.set_addr.addr     = (i == 0) ? 7'h00 : 7'h40;
            end else begin
                k = (i < 17) ? i - 1 : i - 2;
                exp.cmd.rs   = 1'b1;
                exp.cmd.data = model[k];
            end
            check_word($sformatf("%s word %0d", cur_test, i), exp, word_q[i]);
            if (i == 1 || i == 18) begin
                check_gap($sformatf("%s gap %0d", cur_test, i), KIND_US[5] * TICKS + 3,
                          cyc_q[i] - cyc_q[i-1]);
            end else if (i > 0) begin
                check_gap($sformatf("%s gap %0d", cur_test, i), KIND_US[6] * TICKS + 3,
                          cyc_q[i] - cyc_q[i-1]);
            end
        end
        check_gap({cur_test, " done delay"}, KIND_US[6] * TICKS + 2, done_cyc - cyc_q[33]);
    end
endtask

// ************************************************************
// directed tests
// ************************************************************
task automatic run_reset_test();
    start_test("reset_state");
    @(negedge i_clk);
    check_idle_outputs("reset_state in reset");
    @(posedge i_clk);
    #1;
    i_rst_n = 1'b0;
    @(negedge i_clk);
    check_idle_outputs("reset_state after release");
    finish_test();
endtask

task automatic run_init_test();
    start_test("init_sequence");
    while (!o_ready) @(negedge i_clk);
    @(posedge i_clk);
    #1;
    check_count("init_sequence words", 5, word_q.size());
    check_flag("init_sequence busy", 1'b0, o_busy);
    for (int k = 0; k < 5 && k < word_q.size(); k++) begin
        check_word($sformatf("init_sequence word %0d", k), INIT_WORD[k], word_q[k]);
        if (k > 0) begin
            check_gap($sformatf("init_sequence gap %0d", k), KIND_US[k-1] * TICKS + 3,
                      cyc_q[k] - cyc_q[k-1]);
        end
    end
    if (word_q.size() == 5) begin
        check_gap("init_sequence ready delay", KIND_US[4] * TICKS + 2,
                  ready_rise_cyc - cyc_q[4]);
    end
    finish_test();
endtask

task automatic run_blank_test();
    start_test("blank_refresh");
    for (int i = 0; i < 32; i++) begin
        model[i] = 8'h20;   // buffer comes out of reset as spaces
    end
    start_refresh();
    finish_refresh();
    check_refresh();
    finish_test();
endtask

task automatic run_text_test();
    int r;
    start_test("written_text");
    for (int i = 0; i < 32; i++) begin
        r        = $random(seed);
        model[i] = r[7:0];
        write_char(5'(i), r[7:0]);
    end
    start_refresh();
    finish_refresh();
    check_refresh();
    finish_test();
endtask

task automatic run_busy_test();
    start_test("refresh_while_busy");
    start_refresh();
    while (word_q.size() < 2) @(posedge i_clk);
    pulse_refresh();                        // dropped, sequencer is busy
    check_flag("refresh_while_busy busy", 1'b1, o_busy);
    model[31] = ~model[31];
    write_char(5'd31, model[31]);           // lands before index 31 is read
    finish_refresh();
    repeat (2 * (KIND_US[6] * TICKS + 3)) @(posedge i_clk);
    check_refresh();
    finish_test();
endtask

task automatic run_rw_test();
    start_test("rw_level");
    check_count("rw_level words", 5 + 3 * 34, all_q.size());
    foreach (all_q[i]) begin
        check_flag($sformatf("rw_level word %0d", i), 1'b0, all_q[i].cmd.rw);
    end
    finish_test();
endtask

`endif

/* test/tb_lcd_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lcd_top import lcd_pkg::*; ();

    localparam int TICKS = 1;   // clock ticks per microsecond

    // execution time per instruction kind, microseconds
    localparam int KIND_US [0:6] = '{15000, 39, 39, 1530, 39, 39, 43};
    // hd44780 power-up words, rs/rw low
    localparam logic [9:0] INIT_WORD [0:4] = '{10'h030, 10'h038, 10'h00c, 10'h001, 10'h006};

    localparam int INIT_CYC    = (KIND_US[0] + KIND_US[1] + KIND_US[2] + KIND_US[3]
                                  + KIND_US[4]) * TICKS + 5 * 3;
    localparam int REFRESH_CYC = 2 * (KIND_US[5] * TICKS + 3) + 32 * (KIND_US[6] * TICKS + 3);
    localparam int CYCLE_LIMIT = (INIT_CYC + 3 * REFRESH_CYC) * 11 / 10;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_wr_en;
    logic [4:0] i_wr_addr;
    logic [7:0] i_wr_char;
    logic       i_refresh;
    logic       o_lcd_en;
    logic       o_lcd_rs;
    logic       o_lcd_rw;
    logic [7:0] o_lcd_data;
    logic       o_ready;
    logic       o_busy;
    logic       o_done;
    lcd_word_u  bus_word;

    int         cyc_cnt = 0;
    lcd_word_u  word_q [$];     // en words of the current sequence
    int         cyc_q [$];
    lcd_word_u  all_q [$];      // every en word of the run
    int         done_cnt = 0;
    int         done_cyc = 0;
    int         done_base = 0;
    int         ready_rise_cyc = 0;
    logic       ready_d = 1'b0;

    int         n_tests = 0;
    int         n_checks = 0;
    int         n_errors = 0;
    int         test_errors = 0;
    string      cur_test;
    int         seed;
    logic [7:0] model [0:31];   // expected buffer contents

    assign bus_word = {o_lcd_rs, o_lcd_rw, o_lcd_data};

    lcd_top #(
        .TICKS_PER_US(TICKS)
    ) DUT (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_char (i_wr_char),
        .i_refresh (i_refresh),
        .o_lcd_en  (o_lcd_en),
        .o_lcd_rs  (o_lcd_rs),
        .o_lcd_rw  (o_lcd_rw),
        .o_lcd_data(o_lcd_data),
        .o_ready   (o_ready),
        .o_busy    (o_busy),
        .o_done    (o_done)
    );

    initial i_clk = 1'b0;
    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cyc_cnt = cyc_cnt + 1;
        if (cyc_cnt > CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ************************************************************
    // bus monitor, sampled mid-cycle
    // ************************************************************
    always @(negedge i_clk) begin
        if (o_lcd_en) begin
            word_q.push_back(bus_word);
            cyc_q.push_back(cyc_cnt);
            all_q.push_back(bus_word);
        end
        if (o_done) begin
            done_cnt++;
            done_cyc = cyc_cnt;
        end
        if (o_ready && !ready_d) begin
            ready_rise_cyc = cyc_cnt;
        end
        ready_d = o_ready;
    end

    task automatic write_char(input logic [4:0] addr, input logic [7:0] c);
        @(posedge i_clk);
        #1;
        i_wr_en   = 1'b1;
        i_wr_addr = addr;
        i_wr_char = c;
        @(posedge i_clk);
        #1;
        i_wr_en   = 1'b0;
    endtask

    task automatic pulse_refresh();
        @(posedge i_clk);
        #1;
        i_refresh = 1'b1;
        @(posedge i_clk);
        #1;
        i_refresh = 1'b0;
    endtask

    task automatic start_refresh();
        word_q.delete();
        cyc_q.delete();
        done_base = done_cnt;
        pulse_refresh();
    endtask

    task automatic finish_refresh();
        while (!o_done) @(negedge i_clk);
        @(posedge i_clk);   // monitor has logged the pulse by now
        #1;
    endtask

    `include "tb_lcd_tasks.svh"

    initial begin
        seed      = 32'hfc6d_2c6f;
        i_rst_n   = 1'b1;
        i_wr_en   = 1'b0;
        i_wr_addr = 5'd0;
        i_wr_char = 8'd0;
        i_refresh = 1'b0;
        run_reset_test();
        run_init_test();
        run_blank_test();
        run_text_test();
        run_busy_test();
        run_rw_test();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* lcd_top.f */
+incdir+test
verilog/lcd_pkg.sv
verilog/lcd_exec_timer.sv
verilog/lcd_instructions.sv
verilog/lcd_sequencer.sv
verilog/lcd_char_buffer.sv
verilog/lcd_top.sv
test/tb_lcd_top.sv

/* run_sim.sh */
#!/bin/sh
# build the lcd controller testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module tb_lcd_top -f lcd_top.f &&
    out=$(./obj_dir/Vtb_lcd_top) &&
    echo "$out" &&
    echo "$out" | grep -q "TEST PASS" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
